// File: verilog/vfg_pkg.sv
// video frame grabber shared definitions
`default_nettype none

package vfg_pkg;

	// ----------------------------------------------------------
	// widths
	// ----------------------------------------------------------
	localparam int pix_w  = 16;	// stored rgb565 word
	localparam int byte_w = 8;	// one decoder byte
	localparam int prod_w = 21;	// signed products and sums

	// gains scaled by 256
	localparam logic signed [prod_w-1:0] coef_y  = 21'sd298;	// 1.164
	localparam logic signed [prod_w-1:0] coef_rv = 21'sd409;	// 1.596
	localparam logic signed [prod_w-1:0] coef_gu = 21'sd100;	// 0.392
	localparam logic signed [prod_w-1:0] coef_gv = 21'sd208;	// 0.813
	localparam logic signed [prod_w-1:0] coef_bu = 21'sd516;	// 2.017

	localparam logic signed [prod_w-1:0] y_offset = 21'sd16;	// black level
	localparam logic signed [prod_w-1:0] c_offset = 21'sd128;	// chroma zero

	// ----------------------------------------------------------
	// host bus fsm, one-hot
	// ----------------------------------------------------------
	localparam logic [2:0] st_idle         = 3'b001;
	localparam logic [2:0] st_host_rd      = 3'b010;	// memory read running
	localparam logic [2:0] st_host_rd_last = 3'b100;	// rdx released

	// pixel word, split colour view or plain memory word
	typedef union packed {
		struct packed {
			logic [4:0] r;
			logic [5:0] g;
			logic [4:0] b;
		} rgb;
		logic [pix_w-1:0] raw;
	} pix_word_u;

endpackage

`default_nettype wire

// File: verilog/ycbcr_to_rgb565.sv
// ycbcr 4:2:2 to rgb565 converter
`timescale 1ns/1ps
`default_nettype none

module ycbcr_to_rgb565 (
	input  wire                            clk_llc,
	input  wire                            resetx,
	input  wire                            line_active,	// kept line, bytes flowing
	input  wire  [vfg_pkg::byte_w-1:0]     vpo,
	output logic                           pix_valid,
	output vfg_pkg::pix_word_u             pix
);

	logic [1:0]                        phase;	// cb, y0, cr, y1 order
	logic [vfg_pkg::byte_w-1:0]        cb;
	logic [vfg_pkg::byte_w-1:0]        y0;
	logic [vfg_pkg::byte_w-1:0]        cr;
	logic [vfg_pkg::byte_w-1:0]        y1;
	logic                              smp_valid;	// last byte of a pixel sampled
	logic                              smp_odd;	// second pixel of the pair
	logic                              mul_valid;
	logic [vfg_pkg::byte_w-1:0]        y_sel;
	logic signed [vfg_pkg::prod_w-1:0] y_prod;
	logic signed [vfg_pkg::prod_w-1:0] rv_prod;
	logic signed [vfg_pkg::prod_w-1:0] gu_prod;
	logic signed [vfg_pkg::prod_w-1:0] gv_prod;
	logic signed [vfg_pkg::prod_w-1:0] bu_prod;
	logic signed [vfg_pkg::prod_w-1:0] r_sum;
	logic signed [vfg_pkg::prod_w-1:0] g_sum;
	logic signed [vfg_pkg::prod_w-1:0] b_sum;

	// zero-extend, remove offset, scale by four
	function automatic logic signed [vfg_pkg::prod_w-1:0] centered(
		input logic [vfg_pkg::byte_w-1:0]        comp,
		input logic signed [vfg_pkg::prod_w-1:0] off
	);
		logic signed [vfg_pkg::prod_w-1:0] ext;
		ext = $signed({{(vfg_pkg::prod_w - vfg_pkg::byte_w){1'b0}}, comp});
		return (ext - off) <<< 2;
	endfunction

	// ----------------------------------------------------------
	// byte phase and component capture
	// ----------------------------------------------------------
	always_ff @(posedge clk_llc or negedge resetx)
		if (!resetx)
			phase <= 2'd0;
		else if (line_active)
			phase <= phase + 2'd1;
		else
			phase <= 2'd0;	// realign at every line start

	always_ff @(posedge clk_llc)
		if (line_active)
		begin
			case (phase)
				2'd0:    cb <= vpo;
				2'd1:    y0 <= vpo;
				2'd2:    cr <= vpo;
				default: y1 <= vpo;
			endcase
		end

	// pixel done on cr (even) or y1 (odd)
	always_ff @(posedge clk_llc or negedge resetx)
		if (!resetx)
		begin
			smp_valid <= 1'b0;
			smp_odd   <= 1'b0;
			mul_valid <= 1'b0;
			pix_valid <= 1'b0;
		end
		else
		begin
			smp_valid <= line_active & phase[1];
			smp_odd   <= phase[0];
			mul_valid <= smp_valid;
			pix_valid <= mul_valid;	// sum stage done
		end

	assign y_sel = smp_odd ? y1 : y0;

	// ----------------------------------------------------------
	// multiply and sum stages
	// ----------------------------------------------------------
	always_ff @(posedge clk_llc)
		if (smp_valid)
		begin
			y_prod  <= vfg_pkg::coef_y  * centered(y_sel, vfg_pkg::y_offset);
			rv_prod <= vfg_pkg::coef_rv * centered(cr, vfg_pkg::c_offset);
			gv_prod <= vfg_pkg::coef_gv * centered(cr, vfg_pkg::c_offset);
			gu_prod <= vfg_pkg::coef_gu * centered(cb, vfg_pkg::c_offset);
			bu_prod <= vfg_pkg::coef_bu * centered(cb, vfg_pkg::c_offset);
		end

	always_ff @(posedge clk_llc)
		if (mul_valid)
		begin
			r_sum <= y_prod + rv_prod;
			g_sum <= y_prod - gv_prod - gu_prod;
			b_sum <= y_prod + bu_prod;
		end

	// clamp below 0 and at 2^18, then take the top bits
	always_comb
	begin
		pix.rgb.r = r_sum[vfg_pkg::prod_w-1] ? 5'd0 : (|r_sum[19:18]) ? 5'h1f : r_sum[17:13];
		pix.rgb.g = g_sum[vfg_pkg::prod_w-1] ? 6'd0 : (|g_sum[19:18]) ? 6'h3f : g_sum[17:12];
		pix.rgb.b = b_sum[vfg_pkg::prod_w-1] ? 5'd0 : (|b_sum[19:18]) ? 5'h1f : b_sum[17:13];
	end

endmodule

`default_nettype wire

// File: verilog/capture_timing.sv
// field and line capture timing
`timescale 1ns/1ps
`default_nettype none

module capture_timing #(
	parameter int addr_w  = 16,	// top bit is the bank
	parameter int h_decim = 4
) (
	input  wire                         clk_llc,
	input  wire                         resetx,
	input  wire                         vref,
	input  wire                         href,
	input  wire                         odd,
	input  wire                         pix_valid,
	input  wire  [vfg_pkg::pix_w-1:0]   pix,
	output logic                        line_active,
	output logic                        wr_en,
	output logic [addr_w-1:0]           wr_addr,
	output logic [vfg_pkg::pix_w-1:0]   wr_data,
	output logic                        done_bank,
	output logic                        irq0,	// bank 1 completed
	output logic                        irq1	// bank 0 completed
);

	localparam int dec_w = (h_decim > 1) ? $clog2(h_decim) : 1;

	logic              field;	// odd field level
	logic              field_d;
	logic              field_rise;
	logic              field_fall;
	logic              href_d;
	logic              href_rise;
	logic              href_fall;
	logic              line_odd;	// line parity within field
	logic [dec_w-1:0]  dec_cnt;	// pixel index mod h_decim
	logic              pix_keep;
	logic [addr_w-2:0] wr_idx;
	logic              bank;
	logic [2:0]        fall_tap;	// field fall delay line

	assign field      = odd & vref;
	assign field_rise = field & ~field_d;
	assign field_fall = ~field & field_d;
	assign href_rise  = href & ~href_d;
	assign href_fall  = ~href & href_d;

	always_ff @(posedge clk_llc or negedge resetx)
		if (!resetx)
		begin
			field_d <= 1'b0;
			href_d  <= 1'b0;
		end
		else
		begin
			field_d <= field;
			href_d  <= href;
		end

	// ----------------------------------------------------------
	// line and pixel selection
	// ----------------------------------------------------------
	always_ff @(posedge clk_llc or negedge resetx)
		if (!resetx)
			line_odd <= 1'b0;
		else if (!field)
			line_odd <= 1'b0;	// first line of a field is kept
		else if (href_fall)
			line_odd <= ~line_odd;

	assign line_active = href & field & ~line_odd;

	always_ff @(posedge clk_llc or negedge resetx)
		if (!resetx)
			dec_cnt <= '0;
		else if (href_rise)
			dec_cnt <= '0;
		else if (pix_valid)
			dec_cnt <= (dec_cnt == dec_w'(h_decim - 1)) ? '0 : dec_cnt + 1'b1;

	assign pix_keep = pix_valid & (dec_cnt == '0);

	// ----------------------------------------------------------
	// write port, index and bank
	// ----------------------------------------------------------
	always_ff @(posedge clk_llc or negedge resetx)
		if (!resetx)
			wr_en <= 1'b0;
		else
			wr_en <= pix_keep;

	always_ff @(posedge clk_llc)
		if (pix_keep)
			wr_data <= pix;

	always_ff @(posedge clk_llc or negedge resetx)
		if (!resetx)
			wr_idx <= '0;
		else if (field_rise)
			wr_idx <= '0;
		else if (wr_en)
			wr_idx <= wr_idx + 1'b1;	// next word of the field

	assign wr_addr = {bank, wr_idx};

	always_ff @(posedge clk_llc or negedge resetx)
		if (!resetx)
		begin
			bank      <= 1'b0;	// first field lands in bank 1
			done_bank <= 1'b0;
		end
		else
		begin
			if (field_rise)
				bank <= ~bank;
			if (field_fall)
				done_bank <= bank;
		end

	// irq two cycles after the fall, two cycles wide
	always_ff @(posedge clk_llc or negedge resetx)
		if (!resetx)
		begin
			fall_tap <= 3'b000;
			irq0     <= 1'b0;
			irq1     <= 1'b0;
		end
		else
		begin
			fall_tap <= {fall_tap[1:0], field_fall};
			irq0     <= (fall_tap[1] | fall_tap[2]) & done_bank;
			irq1     <= (fall_tap[1] | fall_tap[2]) & ~done_bank;
		end

endmodule

`default_nettype wire

// File: verilog/frame_buffer_ram.sv
// two-bank frame buffer memory
`timescale 1ns/1ps
`default_nettype none

module frame_buffer_ram #(
	parameter int addr_w = 16
) (
	input  wire                        clk_llc,
	input  wire                        wr_en,
	input  wire  [addr_w-1:0]          wr_addr,
	input  wire  [vfg_pkg::pix_w-1:0]  wr_data,
	input  wire                        rd_en,
	input  wire  [addr_w-1:0]          rd_addr,
	output logic [vfg_pkg::pix_w-1:0]  rd_q
);

	logic [vfg_pkg::pix_w-1:0] mem [2**addr_w];	// both banks

	always_ff @(posedge clk_llc)
		if (wr_en)
			mem[wr_addr] <= wr_data;

	// registered read, host side only
	always_ff @(posedge clk_llc)
		if (rd_en)
			rd_q <= mem[rd_addr];

endmodule

`default_nettype wire

// File: verilog/host_bus_fsm.sv
// host read bus controller
`timescale 1ns/1ps
`default_nettype none

module host_bus_fsm #(
	parameter int addr_w    = 16,
	parameter int wait_hold = 10	// cycles of wait after a write
) (
	input  wire                        clk_llc,
	input  wire                        resetx,
	input  wire                        csx,
	input  wire                        rdx,
	input  wire                        wr_en,	// video write strobe
	input  wire                        done_bank,
	input  wire  [addr_w-2:0]          host_adr,
	input  wire  vfg_pkg::pix_word_u   rd_q,
	output logic                       rd_en,
	output logic [addr_w-1:0]          rd_addr,
	output logic [vfg_pkg::pix_w-1:0]  rd_data,
	output logic                       waitx
);

	localparam int cnt_w = $clog2(wait_hold + 1);

	logic [2:0]       state;
	logic [2:0]       state_nx;
	logic [cnt_w-1:0] wait_cnt;	// cycles left in the stretch
	logic             rd_start;

	// ----------------------------------------------------------
	// wait stretch
	// ----------------------------------------------------------
	always_ff @(posedge clk_llc or negedge resetx)
		if (!resetx)
			wait_cnt <= '0;
		else if (wr_en)
			wait_cnt <= cnt_w'(wait_hold);	// restart on every write
		else if (wait_cnt != '0)
			wait_cnt <= wait_cnt - 1'b1;

	// low only while selected and a write is recent
	assign waitx = csx | (~wr_en & (wait_cnt == '0));

	// ----------------------------------------------------------
	// read state machine
	// ----------------------------------------------------------
	assign rd_start = ~csx & ~rdx & waitx;

	always_ff @(posedge clk_llc or negedge resetx)
		if (!resetx)
			state <= vfg_pkg::st_idle;
		else
			state <= state_nx;

	always_comb
	begin
		state_nx = vfg_pkg::st_idle;
		case (state)
			vfg_pkg::st_idle:
				if (rd_start)
					state_nx = vfg_pkg::st_host_rd;
			vfg_pkg::st_host_rd:
				if (rdx)
					state_nx = vfg_pkg::st_host_rd_last;	// strobe released
				else
					state_nx = vfg_pkg::st_host_rd;
			vfg_pkg::st_host_rd_last:
				state_nx = vfg_pkg::st_idle;
			default:
				state_nx = vfg_pkg::st_idle;
		endcase
	end

	assign rd_en   = (state == vfg_pkg::st_host_rd);
	assign rd_addr = {done_bank, host_adr};	// completed bank only

	// bus idles at zero when not selected
	assign rd_data = csx ? '0 : rd_q.raw;

endmodule

`default_nettype wire

// File: verilog/video_frame_grabber.sv
// video frame grabber top level
`timescale 1ns/1ps
`default_nettype none

module video_frame_grabber #(
	parameter int addr_w    = 16,
	parameter int h_decim   = 4,
	parameter int wait_hold = 10
) (
	input  wire                        clk_llc,
	input  wire                        resetx,
	input  wire                        vref,
	input  wire                        href,
	input  wire                        odd,
	input  wire  [vfg_pkg::byte_w-1:0] vpo,
	input  wire                        csx,
	input  wire                        rdx,
	input  wire  [addr_w-2:0]          host_adr,
	output logic [vfg_pkg::pix_w-1:0]  rd_data,
	output logic                       waitx,
	output logic                       irq0,
	output logic                       irq1
);

	logic                      line_active;
	logic                      pix_valid;
	vfg_pkg::pix_word_u        pix;	// converted pixel
	logic                      wr_en;
	logic [addr_w-1:0]         wr_addr;
	logic [vfg_pkg::pix_w-1:0] wr_data;
	logic                      done_bank;
	logic                      rd_en;
	logic [addr_w-1:0]         rd_addr;
	vfg_pkg::pix_word_u        mem_q;	// buffer read word

	// ----------------------------------------------------------
	// video side
	// ----------------------------------------------------------
	capture_timing #(
		.addr_w  (addr_w),
		.h_decim (h_decim)
	) capture_timing_inst (
		.clk_llc     (clk_llc),
		.resetx      (resetx),
		.vref        (vref),
		.href        (href),
		.odd         (odd),
		.pix_valid   (pix_valid),
		.pix         (pix),
		.line_active (line_active),
		.wr_en       (wr_en),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.done_bank   (done_bank),
		.irq0        (irq0),
		.irq1        (irq1)
	);

	ycbcr_to_rgb565 ycbcr_to_rgb565_inst (
		.clk_llc     (clk_llc),
		.resetx      (resetx),
		.line_active (line_active),
		.vpo         (vpo),
		.pix_valid   (pix_valid),
		.pix         (pix)
	);

	// ----------------------------------------------------------
	// memory and host side
	// ----------------------------------------------------------
	frame_buffer_ram #(
		.addr_w (addr_w)
	) frame_buffer_ram_inst (
		.clk_llc (clk_llc),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.rd_q    (mem_q)
	);

	host_bus_fsm #(
		.addr_w    (addr_w),
		.wait_hold (wait_hold)
	) host_bus_fsm_inst (
		.clk_llc   (clk_llc),
		.resetx    (resetx),
		.csx       (csx),
		.rdx       (rdx),
		.wr_en     (wr_en),	// drives the wait stretch
		.done_bank (done_bank),
		.host_adr  (host_adr),
		.rd_q      (mem_q),
		.rd_en     (rd_en),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data),
		.waitx     (waitx)
	);

endmodule

`default_nettype wire

// File: sim/tb_video_frame_grabber.sv
// video frame grabber testbench
`timescale 1ns/1ps
`default_nettype none

module tb_video_frame_grabber;

	localparam int addr_w          = 8;
	localparam int h_decim         = 4;
	localparam int clk_period      = 8;
	localparam int line_bytes      = 64;	// 32 pixels per line
	localparam int lines_per_field = 4;
	localparam int hblank          = 16;
	localparam int vblank_pre      = 8;
	localparam int vblank_post     = 24;
	localparam int n_fields        = 2;
	localparam int kept_per_field  = 16;	// 2 kept lines of 8
	localparam int golden_rows     = 32;
	localparam int read_wait_limit = 200;	// longest stall, a whole kept line
	localparam int field_cycles    = vblank_pre + lines_per_field * (line_bytes + hblank)
		+ vblank_post;
	localparam int margin_cycles   = 3000;	// reads and reset
	localparam int timeout_ns      = (n_fields * field_cycles + margin_cycles) * clk_period;

	logic              clk_llc;
	logic              resetx;
	logic              vref;
	logic              href;
	logic              odd;
	logic [7:0]        vpo;
	logic              csx;
	logic              rdx;
	logic [addr_w-2:0] host_adr;
	logic [15:0]       rd_data;
	logic              waitx;
	logic              irq0;
	logic              irq1;

	logic [15:0] golden_mem [0:golden_rows*4-1];	// y, cb, cr, expected
	int          seed;
	int          error_count;
	int          check_count;
	int          cur_line;	// line number of the field being sent
	int          wr_count;
	int          wr_skipped;	// writes seen during dropped lines
	int          irq0_cycles;
	int          irq1_cycles;
	int          wait_low_cycles;

	video_frame_grabber #(
		.addr_w  (addr_w),
		.h_decim (h_decim)
	) video_frame_grabber_inst (
		.clk_llc  (clk_llc),
		.resetx   (resetx),
		.vref     (vref),
		.href     (href),
		.odd      (odd),
		.vpo      (vpo),
		.csx      (csx),
		.rdx      (rdx),
		.host_adr (host_adr),
		.rd_data  (rd_data),
		.waitx    (waitx),
		.irq0     (irq0),
		.irq1     (irq1)
	);

	initial
	begin
		clk_llc = 1'b0;
		forever #(clk_period/2) clk_llc = ~clk_llc;
	end

	// ----------------------------------------------------------
	// compare and report
	// ----------------------------------------------------------
	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string msg);
		check_count++;
		if (got !== exp)
		begin
			error_count++;
			$display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
		end
	endtask

	// monitors, sampled mid-cycle
	always @(negedge clk_llc)
	begin
		if (resetx && video_frame_grabber_inst.wr_en === 1'b1)
		begin
			wr_count++;
			if (cur_line % 2 == 1)
				wr_skipped++;	// odd lines must stay silent
		end
		if (irq0 === 1'b1)
			irq0_cycles++;
		if (irq1 === 1'b1)
			irq1_cycles++;
		if (resetx && waitx === 1'b0)
			wait_low_cycles++;
	end

	// ----------------------------------------------------------
	// video source
	// ----------------------------------------------------------
	// byte b of line l, golden bytes at the kept pixel slots
	function automatic logic [7:0] line_byte(input int row_base, input int l, input int b,
		input logic [7:0] filler);
		int row;
		row = row_base + (l / 2) * 8 + b / 8;
		if (l % 2 == 1)
			return filler;
		case (b % 8)
			0:       return golden_mem[row*4+1][7:0];	// cb
			1:       return golden_mem[row*4][7:0];	// y of kept pixel
			2:       return golden_mem[row*4+2][7:0];	// cr
			default: return filler;
		endcase
	endfunction

	task automatic send_field(input int row_base);
		int rnd;
		cur_line = 0;
		@(negedge clk_llc);
		odd  = 1'b1;
		vref = 1'b1;	// odd field opens
		repeat (vblank_pre) @(negedge clk_llc);
		for (int l = 0; l < lines_per_field; l++)
		begin
			cur_line = l;
			for (int b = 0; b < line_bytes; b++)
			begin
				rnd  = $random(seed);
				href = 1'b1;
				vpo  = line_byte(row_base, l, b, rnd[7:0]);
				@(negedge clk_llc);
			end
			href = 1'b0;
			vpo  = 8'h00;
			repeat (hblank) @(negedge clk_llc);
		end
		vref = 1'b0;	// field closes, irq follows
		odd  = 1'b0;
		repeat (vblank_post) @(negedge clk_llc);
	endtask

	// ----------------------------------------------------------
	// host side
	// ----------------------------------------------------------
	task automatic host_read(input int idx, output logic [15:0] data);
		int waited;
		waited = 0;
		@(negedge clk_llc);
		host_adr = (addr_w-1)'(idx);
		rdx      = 1'b0;
		#(clk_period/4);
		while (waitx !== 1'b1 && waited < read_wait_limit)	// held off by waitx
		begin
			@(negedge clk_llc);
			#(clk_period/4);
			waited++;
		end
		if (waitx !== 1'b1)
		begin
			error_count++;
			$display("host read of index %0d never saw waitx released", idx);
		end
		@(posedge clk_llc);	// fsm enters host_rd
		@(posedge clk_llc);	// memory word registered
		@(negedge clk_llc);
		data = rd_data;
		rdx  = 1'b1;
		@(negedge clk_llc);	// back to idle
	endtask

	task automatic read_field(input int row_base, input string tag);
		logic [15:0] data;
		@(negedge clk_llc);
		csx = 1'b0;
		for (int k = 0; k < kept_per_field; k++)
		begin
			host_read(k, data);
			check_value(32'(data), 32'(golden_mem[(row_base+k)*4+3]),
				$sformatf("%s index %0d", tag, k));
		end
		@(negedge clk_llc);
		csx = 1'b1;
	endtask

	// ----------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------
	initial
	begin
		resetx          = 1'b0;
		vref            = 1'b0;
		href            = 1'b0;
		odd             = 1'b0;
		vpo             = 8'h00;
		csx             = 1'b1;
		rdx             = 1'b1;
		host_adr        = '0;
		seed            = 32'h09d57b72;
		error_count     = 0;
		check_count     = 0;
		cur_line        = 0;
		wr_count        = 0;
		wr_skipped      = 0;
		irq0_cycles     = 0;
		irq1_cycles     = 0;
		wait_low_cycles = 0;
		$readmemh("sim/video_golden.txt", golden_mem);

		repeat (10) @(negedge clk_llc);
		resetx = 1'b1;
		@(negedge clk_llc);
		csx = 1'b0;	// selected, no write yet
		@(negedge clk_llc);
		check_value(32'(waitx), 32'd1, "waitx after reset");
		check_value(32'(irq0), 32'd0, "irq0 after reset");
		check_value(32'(irq1), 32'd0, "irq1 after reset");
		csx = 1'b1;

		// field 1 lands in bank 1
		send_field(0);
		check_value(wr_count, kept_per_field, "writes in field 1");
		check_value(wr_skipped, 0, "writes on dropped lines, field 1");
		check_value(irq0_cycles, 2, "irq0 pulse after field 1");
		check_value(irq1_cycles, 0, "irq1 quiet after field 1");
		read_field(0, "field 1");

		// field 2 into bank 0 while the host reads bank 1
		fork
			send_field(kept_per_field);
			read_field(0, "field 1 during capture");
		join
		check_value(32'(wait_low_cycles > 0), 32'd1, "waitx low during capture");
		check_value(wr_count, 2 * kept_per_field, "writes after field 2");
		check_value(wr_skipped, 0, "writes on dropped lines, field 2");
		check_value(irq0_cycles, 2, "irq0 quiet after field 2");
		check_value(irq1_cycles, 2, "irq1 pulse after field 2");
		read_field(kept_per_field, "field 2");

		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// watchdog, two fields plus reads
	initial
	begin
		#(timeout_ns);
		$display("watchdog expired after %0d ns, the run did not finish", timeout_ns);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
verilog/vfg_pkg.sv
verilog/ycbcr_to_rgb565.sv
verilog/capture_timing.sv
verilog/frame_buffer_ram.sv
verilog/host_bus_fsm.sv
verilog/video_frame_grabber.sv
sim/tb_video_frame_grabber.sv

// File: Makefile
# Verilator build and run for the video frame grabber testbench

VERILATOR ?= verilator
TOP       ?= tb_video_frame_grabber
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "RESULT: PASS" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/video_golden.txt
// columns: Y Cb Cr expected_rgb565, one kept pixel per row
// rows 0-15 field 1, rows 16-31 field 2
10 80 80 0000
EB 80 80 FFFF
00 80 80 0000
FF 80 80 FFFF
80 80 80 8410
40 80 80 31A6
60 80 80 5AEB
A0 80 80 A534
C0 80 80 CE79
20 80 80 1082
51 5A F0 F800
91 36 22 07E0
29 F0 6E 001F
80 80 C0 EA70
80 C0 80 835F
80 40 40 1E60
30 80 80 2124
50 80 80 4A49
70 80 80 6B6D
90 80 80 94B2
B0 80 80 BDD7
D0 80 80 DEFB
E0 80 80 F79E
18 80 80 0841
80 80 FF F8D0
80 00 80 85A0
80 FF 00 05DF
40 A0 60 022F
C0 60 A0 FDF1
10 80 90 1800
10 90 80 0004
A0 70 70 8DD0
